/* hw/ocs_pkg.sv */
package ocs_pkg;

    //////////////////////////////
    // Channels and slot timing
    //////////////////////////////

    // One channel per top-of-rack switch
    localparam int CHANNEL_NUM  = 8;

    // Both in clock cycles
    localparam int CONFIG_DELAY = 234;
    localparam int SLOT_LEN     = 2343;

    // Counter must hold the longer of the two phases
    localparam int SLOT_CNT_W   = $clog2(SLOT_LEN);

    //////////////////////////////
    // Transmit stream
    //////////////////////////////

    localparam int DATA_W       = 64;
    localparam int KEEP_W       = DATA_W / 8;

    // Minimum length frame, 64 bytes
    localparam int FRAME_BEATS  = 8;
    localparam int BEAT_CNT_W   = $clog2(FRAME_BEATS);

    //////////////////////////////
    // Control frame fields
    //////////////////////////////

    localparam logic [47:0] MY_MAC       = 48'h8D_BC_5C_4A_1A_1F;

    // Channel index lands in bits 15:8
    localparam logic [47:0] TOR_MAC_BASE = 48'h8D_BC_5C_4A_00_00;

    // Ethertype of the slot-id frame
    localparam logic [15:0] SLOT_ID_TYPE = 16'hff03;

    // One beat on the transmit stream
    typedef struct packed {
        logic [DATA_W-1:0] tdata;
        logic [KEEP_W-1:0] tkeep;
        logic              tlast;
    } axis_beat_t;

endpackage

/* hw/ocs_slot_ctrl.sv */
`timescale 1ns/1ps

module ocs_slot_ctrl (
    input  logic                          i_clk,
    input  logic                          i_rst,

    input  logic [ocs_pkg::CHANNEL_NUM-1:0] i_chnl_ready,

    output logic                          o_slot_start,
    output logic                          o_slot_id
);

    import ocs_pkg::*;

    typedef enum logic [1:0] {
        ST_WAIT_LINK,
        ST_CONFIG,
        ST_SLOT
    } state_t;

    state_t                r_state;
    logic [SLOT_CNT_W-1:0] r_cnt;

    logic                  w_all_ready;
    logic                  w_cfg_done;
    logic                  w_slot_done;

    //////////////////////////////
    // Phase end detection
    //////////////////////////////

    assign w_all_ready = &i_chnl_ready;

    // Last cycle of each phase
    assign w_cfg_done  = (r_cnt == SLOT_CNT_W'(CONFIG_DELAY - 1));
    assign w_slot_done = (r_cnt == SLOT_CNT_W'(SLOT_LEN - 1));

    //////////////////////////////
    // Slot cycle FSM
    //////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_state      <= ST_WAIT_LINK;
            r_cnt        <= '0;
            o_slot_start <= 1'b0;
            o_slot_id    <= 1'b0;
        end else begin
            o_slot_start <= 1'b0;

            case (r_state)
                // Links only gate the very first start
                ST_WAIT_LINK: begin
                    r_cnt <= '0;
                    if (w_all_ready) begin
                        r_state <= ST_CONFIG;
                    end
                end

                // Switch reconfiguration, new slot announced at the end
                ST_CONFIG: begin
                    if (w_cfg_done) begin
                        r_state      <= ST_SLOT;
                        r_cnt        <= '0;
                        o_slot_start <= 1'b1;
                        o_slot_id    <= ~o_slot_id;
                    end else begin
                        r_cnt <= r_cnt + 1'b1;
                    end
                end

                ST_SLOT: begin
                    if (w_slot_done) begin
                        r_state <= ST_CONFIG;
                        r_cnt   <= '0;
                    end else begin
                        r_cnt <= r_cnt + 1'b1;
                    end
                end

                default: begin
                    r_state <= ST_WAIT_LINK;
                    r_cnt   <= '0;
                end
            endcase
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    // Start is a single-cycle event
    a_start_one_cycle: assert property (
        @(posedge i_clk) disable iff (i_rst)
        o_slot_start |=> !o_slot_start
    );

endmodule

/* hw/ocs_frame_tx.sv */
`timescale 1ns/1ps

module ocs_frame_tx #(
    parameter int CHANNEL_ID = 0
) (
    input  logic                i_clk,
    input  logic                i_rst,

    input  logic                i_slot_start,
    input  logic                i_slot_id,

    output logic                o_tx_valid,
    output ocs_pkg::axis_beat_t o_tx_beat,
    input  logic                i_tx_ready
);

    import ocs_pkg::*;

    logic                  r_busy;
    logic [BEAT_CNT_W-1:0] r_beat_cnt;
    logic                  r_slot_id;

    logic [47:0]           w_tor_mac;
    logic                  w_xfer;
    logic                  w_last_beat;

    // Destination ToR address for this channel
    assign w_tor_mac   = {TOR_MAC_BASE[47:16], 8'(CHANNEL_ID), TOR_MAC_BASE[7:0]};

    assign w_xfer      = r_busy & i_tx_ready;
    assign w_last_beat = (r_beat_cnt == BEAT_CNT_W'(FRAME_BEATS - 1));

    assign o_tx_valid  = r_busy;

    //////////////////////////////
    // Frame sequencing
    //////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_busy     <= 1'b0;
            r_beat_cnt <= '0;
        end else if (i_slot_start) begin
            r_busy     <= 1'b1;
            r_beat_cnt <= '0;
        end else if (w_xfer) begin
            // Wraps back to beat 0 after the last one
            r_beat_cnt <= r_beat_cnt + 1'b1;
            if (w_last_beat) begin
                r_busy <= 1'b0;
            end
        end
    end

    // Slot id is sampled with the start, toggled on that same edge
    always_ff @(posedge i_clk) begin
        if (i_slot_start) begin
            r_slot_id <= i_slot_id;
        end
    end

    //////////////////////////////
    // Beat contents
    //////////////////////////////

    always_comb begin
        o_tx_beat.tkeep = '1;
        o_tx_beat.tlast = w_last_beat;

        case (r_beat_cnt)
            BEAT_CNT_W'(0): begin
                o_tx_beat.tdata = {w_tor_mac, MY_MAC[47:32]};
            end
            BEAT_CNT_W'(1): begin
                o_tx_beat.tdata = {MY_MAC[31:0], SLOT_ID_TYPE, 15'd0, r_slot_id};
            end
            // Pad to minimum length
            default: begin
                o_tx_beat.tdata = '0;
            end
        endcase
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    // A stalled beat must not change until it is taken
    a_hold_under_stall: assert property (
        @(posedge i_clk) disable iff (i_rst)
        (o_tx_valid && !i_tx_ready) |=> (o_tx_valid && $stable(o_tx_beat))
    );

    // Previous frame has to be out before the next slot starts
    a_no_start_while_busy: assert property (
        @(posedge i_clk) disable iff (i_rst)
        i_slot_start |-> !r_busy
    );

endmodule

/* hw/ocs_controller.sv */
`timescale 1ns/1ps

module ocs_controller (
    input  logic                                         i_clk,
    input  logic                                         i_rst,

    // Link status per ToR
    input  logic [ocs_pkg::CHANNEL_NUM-1:0]              i_chnl_ready,

    output logic                                         o_slot_id,

    // Transmit stream per channel
    output logic [ocs_pkg::CHANNEL_NUM-1:0]              o_tx_valid,
    output ocs_pkg::axis_beat_t [ocs_pkg::CHANNEL_NUM-1:0] o_tx_beat,
    input  logic [ocs_pkg::CHANNEL_NUM-1:0]              i_tx_ready
);

    import ocs_pkg::*;

    logic w_slot_start;
    logic w_slot_id;

    assign o_slot_id = w_slot_id;

    //////////////////////////////
    // Slot timing
    //////////////////////////////

    ocs_slot_ctrl u_slot_ctrl (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_chnl_ready (i_chnl_ready),
        .o_slot_start (w_slot_start),
        .o_slot_id    (w_slot_id)
    );

    //////////////////////////////
    // Per-channel frame senders
    //////////////////////////////

    // Every channel announces the same slot, only the ToR MAC differs
    for (genvar c = 0; c < CHANNEL_NUM; c++) begin : g_chnl
        ocs_frame_tx #(
            .CHANNEL_ID (c)
        ) u_frame_tx (
            .i_clk        (i_clk),
            .i_rst        (i_rst),
            .i_slot_start (w_slot_start),
            .i_slot_id    (w_slot_id),
            .o_tx_valid   (o_tx_valid[c]),
            .o_tx_beat    (o_tx_beat[c]),
            .i_tx_ready   (i_tx_ready[c])
        );
    end

endmodule

/* test/ocs_checker.sv */
`timescale 1ns/1ps

module ocs_checker (
    input  logic                                           i_clk,
    input  logic                                           i_rst,
    input  logic [ocs_pkg::CHANNEL_NUM-1:0]                i_chnl_ready,
    input  logic                                           i_slot_id,
    input  logic [ocs_pkg::CHANNEL_NUM-1:0]                i_tx_valid,
    input  ocs_pkg::axis_beat_t [ocs_pkg::CHANNEL_NUM-1:0] i_tx_beat,
    input  logic [ocs_pkg::CHANNEL_NUM-1:0]                i_tx_ready,
    output int                                             o_err_cnt,
    output int                                             o_frame_cnt
);

    import ocs_pkg::*;

    int                     err_cnt = 0;
    int                     frame_cnt = 0;
    int                     cycle;
    int                     next_start;
    logic                   armed;
    logic                   pend_start;
    logic                   exp_id;
    logic                   frame_id;
    logic [CHANNEL_NUM-1:0] exp_busy;
    int                     beat_idx [CHANNEL_NUM];

    assign o_err_cnt   = err_cnt;
    assign o_frame_cnt = frame_cnt;

    //////////////////////////////
    // Reference frame layout
    //////////////////////////////

    function automatic axis_beat_t expected_beat(int chnl, int idx, logic id);
        axis_beat_t  beat;
        logic [47:0] tor_mac;
        tor_mac       = TOR_MAC_BASE;
        tor_mac[15:8] = chnl[7:0];
        beat.tkeep    = '1;
        beat.tlast    = (idx == FRAME_BEATS - 1);
        beat.tdata    = '0;
        if (idx == 0) begin
            beat.tdata = {tor_mac, MY_MAC[47:32]};
        end else if (idx == 1) begin
            beat.tdata = {MY_MAC[31:0], SLOT_ID_TYPE, 15'd0, id};
        end
        return beat;
    endfunction

    task automatic mismatch(input string msg);
        $display("mismatch at %0t: %s", $time, msg);
        err_cnt++;
    endtask

    //////////////////////////////
    // Cycle model
    //////////////////////////////

    always @(posedge i_clk) begin
        axis_beat_t exp_beat;
        if (i_rst) begin
            cycle      = 0;
            next_start = 0;
            armed      = 1'b0;
            pend_start = 1'b0;
            exp_id     = 1'b0;
            frame_id   = 1'b0;
            exp_busy   = '0;
            for (int c = 0; c < CHANNEL_NUM; c++) begin
                beat_idx[c] = 0;
            end
        end else begin
            cycle = cycle + 1;

            // Observed values belong to the previous edge
            if (i_slot_id !== exp_id) begin
                mismatch($sformatf("slot id %b, expected %b", i_slot_id, exp_id));
            end
            for (int c = 0; c < CHANNEL_NUM; c++) begin
                if (i_tx_valid[c] !== exp_busy[c]) begin
                    mismatch($sformatf("chnl %0d valid %b, expected %b",
                                       c, i_tx_valid[c], exp_busy[c]));
                end else if (exp_busy[c]) begin
                    exp_beat = expected_beat(c, beat_idx[c], frame_id);
                    if (i_tx_beat[c] !== exp_beat) begin
                        mismatch($sformatf("chnl %0d beat %0d is %h, expected %h",
                                           c, beat_idx[c], i_tx_beat[c], exp_beat));
                    end
                end
            end

            // Advance the model by this edge
            if (pend_start) begin
                frame_id = exp_id;
            end
            for (int c = 0; c < CHANNEL_NUM; c++) begin
                if (pend_start) begin
                    exp_busy[c] = 1'b1;
                    beat_idx[c] = 0;
                end else if (exp_busy[c] && i_tx_ready[c]) begin
                    if (beat_idx[c] == FRAME_BEATS - 1) begin
                        exp_busy[c] = 1'b0;
                        frame_cnt++;
                    end
                    beat_idx[c] = beat_idx[c] + 1;
                end
            end
            pend_start = 1'b0;

            // Links gate only the first start
            if (!armed && (&i_chnl_ready)) begin
                armed      = 1'b1;
                next_start = cycle + CONFIG_DELAY;
            end else if (armed && cycle == next_start) begin
                exp_id     = ~exp_id;
                pend_start = 1'b1;
                next_start = next_start + SLOT_LEN + CONFIG_DELAY;
            end
        end
    end

endmodule

/* test/tb_ocs_controller.sv */
`timescale 1ns/1ps

module tb_ocs_controller;

    import ocs_pkg::*;

    localparam logic [1:0] STALL_NONE  = 2'd0;
    localparam logic [1:0] STALL_LIGHT = 2'd1;
    localparam logic [1:0] STALL_HEAVY = 2'd2;

    localparam int ROW_NUM       = 7;
    localparam int RAND_SEED     = 90255;
    localparam int IDLE_CYCLES   = 2 * CONFIG_DELAY;
    localparam int START_TIMEOUT = SLOT_LEN + 2 * CONFIG_DELAY + 16;
    localparam int DRAIN_TIMEOUT = 512;

    typedef struct packed {
        logic [CHANNEL_NUM-1:0] chnl_mask;
        logic [1:0]             stall;
        int                     starts;
    } phase_t;

    logic                              clk;
    logic                              rst;
    logic [CHANNEL_NUM-1:0]            chnl_ready;
    logic                              slot_id;
    logic [CHANNEL_NUM-1:0]            tx_valid;
    axis_beat_t [CHANNEL_NUM-1:0]      tx_beat;
    logic [CHANNEL_NUM-1:0]            tx_ready;

    logic [1:0]                        stall_level;
    logic                              timed_out;
    int                                timeout_cnt;
    int                                err_cnt;
    int                                frame_cnt;
    phase_t                            phases [ROW_NUM];

    initial clk = 1'b0;
    always #5 clk = ~clk;

    ocs_controller u_ocs_controller (
        .i_clk        (clk),
        .i_rst        (rst),
        .i_chnl_ready (chnl_ready),
        .o_slot_id    (slot_id),
        .o_tx_valid   (tx_valid),
        .o_tx_beat    (tx_beat),
        .i_tx_ready   (tx_ready)
    );

    ocs_checker u_checker (
        .i_clk        (clk),
        .i_rst        (rst),
        .i_chnl_ready (chnl_ready),
        .i_slot_id    (slot_id),
        .i_tx_valid   (tx_valid),
        .i_tx_beat    (tx_beat),
        .i_tx_ready   (tx_ready),
        .o_err_cnt    (err_cnt),
        .o_frame_cnt  (frame_cnt)
    );

    //////////////////////////////
    // Back-pressure
    //////////////////////////////

    initial begin
        void'($urandom(RAND_SEED));
        forever begin
            @(posedge clk);
            for (int c = 0; c < CHANNEL_NUM; c++) begin
                case (stall_level)
                    STALL_NONE:  tx_ready[c] <= 1'b1;
                    STALL_LIGHT: tx_ready[c] <= (($urandom % 4) != 0);
                    default:     tx_ready[c] <= (($urandom % 4) == 0);
                endcase
            end
        end
    end

    //////////////////////////////
    // Phases and waits
    //////////////////////////////

    task automatic load_phases();
        // Partial masks first, seven of eight included
        phases[0] = '{8'h00, STALL_NONE, 0};
        phases[1] = '{8'h7F, STALL_NONE, 0};
        phases[2] = '{8'hFE, STALL_LIGHT, 0};
        phases[3] = '{8'hFF, STALL_NONE, 2};
        phases[4] = '{8'hFF, STALL_LIGHT, 2};
        // Links drop, slots keep running
        phases[5] = '{8'h0F, STALL_HEAVY, 2};
        phases[6] = '{8'h00, STALL_LIGHT, 1};
    endtask

    task automatic wait_slot_start();
        logic prev_id;
        int   waited;
        prev_id = slot_id;
        waited  = 0;
        while (slot_id == prev_id && waited < START_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (slot_id == prev_id) begin
            $display("timeout: no slot start within %0d cycles", START_TIMEOUT);
            timeout_cnt++;
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        repeat (2) @(posedge clk);
        while (tx_valid != '0 && waited < DRAIN_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (tx_valid != '0) begin
            $display("timeout: frames still sending after %0d cycles", DRAIN_TIMEOUT);
            timeout_cnt++;
            timed_out = 1'b1;
        end
    endtask

    task automatic run_phase(input phase_t ph);
        @(posedge clk);
        chnl_ready  <= ph.chnl_mask;
        stall_level <= ph.stall;
        if (ph.starts == 0) begin
            repeat (IDLE_CYCLES) @(posedge clk);
        end else begin
            for (int s = 0; s < ph.starts && !timed_out; s++) begin
                wait_slot_start();
            end
        end
    endtask

    initial begin
        rst         = 1'b1;
        chnl_ready  = '0;
        tx_ready    = '1;
        stall_level = STALL_NONE;
        timed_out   = 1'b0;
        timeout_cnt = 0;
        load_phases();

        repeat (5) @(posedge clk);
        rst <= 1'b0;

        for (int row = 0; row < ROW_NUM; row++) begin
            if (!timed_out) begin
                run_phase(phases[row]);
            end
        end
        if (!timed_out) begin
            wait_drain();
        end
        @(posedge clk);

        $display("errors: mismatches=%0d timeouts=%0d frames=%0d",
                 err_cnt, timeout_cnt, frame_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
hw/ocs_pkg.sv
hw/ocs_slot_ctrl.sv
hw/ocs_frame_tx.sv
hw/ocs_controller.sv
test/ocs_checker.sv
test/tb_ocs_controller.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f \
    --top-module tb_ocs_controller -o sim_ocs \
    && ./obj_dir/sim_ocs | tee /dev/stderr | grep -q "TEST PASSED" \
    && echo "simulation ok" \
    || { echo "simulation failed"; exit 1; }
